/* common/mm_beat_if.sv */
/* Read beat from the sequencer to the operand stores. No ready, a beat is taken
   in every cycle that valid is high */
interface mm_beat_if import mm_cfg_pkg::*; ();

    logic  valid;       // Beat issued this cycle
    logic  first;       // Inner word 0 of a tile
    logic  last;        // Final inner word of a tile
    addr_t a_even_addr; // Even A row word
    addr_t a_odd_addr;  // Odd A row word
    addr_t b_addr;      // B column word
    logic  busy;        // Stores owned by the engine

    modport seq (
        output valid, first, last,
        output a_even_addr, a_odd_addr, b_addr,
        output busy
    );

    modport store (
        input valid, first, last,
        input a_even_addr, a_odd_addr, b_addr,
        input busy
    );

endinterface

/* common/mm_cfg_pkg.sv */
/* Matrix geometry and data widths. Elements are plain signed integers, no fixed point.
   Store words pack ELEMS_PER_WORD elements, lane j in bits 8j+7..8j */
package mm_cfg_pkg;

    // Operand element and store word
    localparam int ELEM_W         = 8;
    localparam int ELEMS_PER_WORD = 4;
    localparam int WORD_W         = ELEM_W * ELEMS_PER_WORD;

    // Inner dimension, shared by A rows and B columns
    localparam int INNER_DIM   = 16;
    localparam int INNER_WORDS = INNER_DIM / ELEMS_PER_WORD; // Words per row or column

    // Outer dimensions of A and B
    localparam int A_ROWS    = 4;
    localparam int B_COLS    = 4;
    localparam int ROW_PAIRS = A_ROWS / 2;         // Even and odd row read together
    localparam int NUM_TILES = ROW_PAIRS * B_COLS; // Results per run

    // Store addressing, A and B stores share the same depth
    localparam int ADDR_W = $clog2(A_ROWS * INNER_WORDS);

    // Result width, far above the 16-product worst case
    localparam int ACC_W = 32;

    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic [WORD_W-1:0]        word_t;
    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // Tile coordinates of a result
    typedef logic [$clog2(ROW_PAIRS)-1:0] pair_idx_t;
    typedef logic [$clog2(B_COLS)-1:0]    col_idx_t;

endpackage

/* common/mm_ctrl_pkg.sv */
/* Sequencer control definitions. PIPE_DEPTH must track the register stages
   between a beat and its out_valid */
package mm_ctrl_pkg;

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE,  // Waiting for start, stores writable
        RUN,   // One beat per cycle
        DRAIN  // Last beats still in flight
    } seq_state_t;

    // Store read, accumulate, writeback
    localparam int PIPE_DEPTH = 3;

endpackage

/* common/mm_operand_if.sv */
/* Operand words of one beat, one cycle after the beat was issued.
   Flags are already aligned with the read data */
interface mm_operand_if import mm_cfg_pkg::*; ();

    logic  valid;
    logic  first;   // Restart the accumulation
    logic  last;    // Close the tile
    word_t a_even;  // Even row word
    word_t a_odd;   // Odd row word
    word_t b_word;  // Shared by both lanes

    modport store (
        output valid, first, last,
        output a_even, a_odd, b_word
    );

    modport acc (
        input valid, first, last,
        input a_even, a_odd, b_word
    );

endinterface

/* design/dot_accumulator.sv */
/* Two lanes share one B word per beat. A tile is INNER_WORDS beats, first
   restarts the sum, so back-to-back tiles need no gap */
module dot_accumulator
    import mm_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    mm_operand_if.acc  opnd,
    output logic       res_valid,
    output acc_t       res_even,
    output acc_t       res_odd
);

    acc_t acc_even;   // Running sums
    acc_t acc_odd;
    acc_t dot_even;   // This beat's word products
    acc_t dot_odd;
    acc_t next_even;
    acc_t next_odd;

    // Signed dot product of the ELEMS_PER_WORD lanes of two words
    function automatic acc_t word_dot(input word_t a, input word_t b);
        elem_t ea;
        elem_t eb;
        acc_t  sum;
        sum = '0;
        for (int j = 0; j < ELEMS_PER_WORD; j++) begin
            ea  = a[j*ELEM_W +: ELEM_W];
            eb  = b[j*ELEM_W +: ELEM_W];
            sum = sum + ea * eb; // Sign extended to ACC_W
        end
        return sum;
    endfunction

    assign dot_even = word_dot(opnd.a_even, opnd.b_word);
    assign dot_odd  = word_dot(opnd.a_odd, opnd.b_word);

    // First beat loads instead of adding
    assign next_even = opnd.first ? dot_even : acc_even + dot_even;
    assign next_odd  = opnd.first ? dot_odd : acc_odd + dot_odd;

    always_ff @(posedge clk) begin
        if (opnd.valid) begin
            acc_even <= next_even;
            acc_odd  <= next_odd;
        end
        if (opnd.valid && opnd.last) begin
            res_even <= next_even; // Final tile sums
            res_odd  <= next_odd;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            res_valid <= 1'b0;
        else
            res_valid <= opnd.valid && opnd.last; // One pulse per tile
    end

endmodule

/* design/matmul_top.sv */
/* Block matrix multiplier, C = A x B^T over 4x16 operands, two results per pulse.
   No back-pressure, each result must be taken in its out_valid cycle */
module matmul_top
    import mm_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      a_wr_en,
    input  addr_t     a_wr_addr,
    input  word_t     a_wr_data,
    input  logic      b_wr_en,
    input  addr_t     b_wr_addr,
    input  word_t     b_wr_data,
    input  logic      start,
    output logic      busy,
    output logic      out_valid,
    output pair_idx_t out_pair,
    output col_idx_t  out_col,
    output acc_t      c_even,
    output acc_t      c_odd,
    output logic      done
);

    logic start_accepted;
    logic res_valid;
    acc_t res_even;
    acc_t res_odd;

    mm_beat_if    beat_bus ();
    mm_operand_if opnd_bus ();

    assign busy = beat_bus.busy;

    tile_sequencer u_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .start_accepted (start_accepted),
        .beat           (beat_bus.seq)
    );

    operand_store u_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_wr_en   (a_wr_en),
        .b_wr_en   (b_wr_en),
        .a_wr_addr (a_wr_addr),
        .b_wr_addr (b_wr_addr),
        .a_wr_data (a_wr_data),
        .b_wr_data (b_wr_data),
        .beat      (beat_bus.store),
        .opnd      (opnd_bus.store)
    );

    dot_accumulator u_acc (
        .clk       (clk),
        .rst_n     (rst_n),
        .opnd      (opnd_bus.acc),
        .res_valid (res_valid),
        .res_even  (res_even),
        .res_odd   (res_odd)
    );

    tile_writeback u_wb (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_accepted (start_accepted),
        .res_valid      (res_valid),
        .res_even       (res_even),
        .res_odd        (res_odd),
        .out_valid      (out_valid),
        .out_pair       (out_pair),
        .out_col        (out_col),
        .c_even         (c_even),
        .c_odd          (c_odd),
        .done           (done)
    );

endmodule

/* design/tile_sequencer.sv */
/* Walks row pairs, then columns, then inner words, one beat per cycle.
   Start is taken only in IDLE, start while busy is dropped */
module tile_sequencer
    import mm_cfg_pkg::*;
    import mm_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    output logic      start_accepted,
    mm_beat_if.seq    beat
);

    seq_state_t                       state;
    logic [$clog2(INNER_WORDS)-1:0]   k_cnt;     // Inner word within a tile
    col_idx_t                         col_cnt;
    pair_idx_t                        pair_cnt;
    logic [$clog2(PIPE_DEPTH)-1:0]    drain_cnt;

    assign start_accepted = start && (state == IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            k_cnt     <= '0;
            col_cnt   <= '0;
            pair_cnt  <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= RUN;
                        k_cnt    <= '0;
                        col_cnt  <= '0;
                        pair_cnt <= '0;
                    end
                end
                RUN: begin
                    k_cnt <= k_cnt + 1'b1; // Wraps to 0 at tile end
                    if (k_cnt == INNER_WORDS - 1) begin
                        if (col_cnt == B_COLS - 1) begin
                            col_cnt <= '0;
                            if (pair_cnt == ROW_PAIRS - 1) begin
                                pair_cnt  <= '0;
                                drain_cnt <= '0;
                                state     <= DRAIN; // Last beat issued
                            end else begin
                                pair_cnt <= pair_cnt + 1'b1;
                            end
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end
                end
                DRAIN: begin
                    // Hold busy until the last out_valid has gone out
                    if (drain_cnt == PIPE_DEPTH - 1)
                        state <= IDLE;
                    else
                        drain_cnt <= drain_cnt + 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign beat.valid = (state == RUN);
    assign beat.first = beat.valid && (k_cnt == 0);
    assign beat.last  = beat.valid && (k_cnt == INNER_WORDS - 1);
    assign beat.busy  = (state != IDLE);   // RUN and DRAIN

    // Row-major word addresses, even row 2p, odd row 2p+1
    assign beat.a_even_addr = addr_t'((2 * pair_cnt) * INNER_WORDS + k_cnt);
    assign beat.a_odd_addr  = addr_t'((2 * pair_cnt + 1) * INNER_WORDS + k_cnt);
    assign beat.b_addr      = addr_t'(col_cnt * INNER_WORDS + k_cnt);

endmodule

/* design/tile_writeback.sv */
/* Results leave in issue order, so the tile count gives pair and column.
   done is sticky until the next accepted start */
module tile_writeback
    import mm_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_accepted,
    input  logic      res_valid,
    input  acc_t      res_even,
    input  acc_t      res_odd,
    output logic      out_valid,
    output pair_idx_t out_pair,
    output col_idx_t  out_col,
    output acc_t      c_even,
    output acc_t      c_odd,
    output logic      done
);

    logic [$clog2(NUM_TILES+1)-1:0] tile_cnt; // Results seen this run

    // Result payload, indices follow the sequencer's column-inner order
    always_ff @(posedge clk) begin
        if (res_valid) begin
            c_even   <= res_even;
            c_odd    <= res_odd;
            out_col  <= col_idx_t'(tile_cnt % B_COLS);
            out_pair <= pair_idx_t'(tile_cnt / B_COLS);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            tile_cnt  <= '0;
            done      <= 1'b0;
        end else begin
            out_valid <= res_valid;
            if (start_accepted) begin
                tile_cnt <= '0;
                done     <= 1'b0; // Low from the cycle after start
            end else begin
                if (res_valid)
                    tile_cnt <= tile_cnt + 1'b1;
                // Set one cycle after the last out_valid
                if (out_valid && tile_cnt == NUM_TILES)
                    done <= 1'b1;
            end
        end
    end

endmodule

/* matmul.f */
common/mm_cfg_pkg.sv
common/mm_ctrl_pkg.sv
common/mm_beat_if.sv
common/mm_operand_if.sv
operand_store/operand_ram.sv
operand_store/operand_store.sv
design/tile_sequencer.sv
design/dot_accumulator.sv
design/tile_writeback.sv
design/matmul_top.sv
verif/matmul_props.sv
verif/matmul_tb.sv

/* operand_store/operand_ram.sv */
/* One write port, NUM_RD registered read ports, read latency one.
   A read of the address being written returns the old word */
module operand_ram
    import mm_cfg_pkg::*;
#(
    parameter int NUM_RD = 1
) (
    input  logic  clk,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  word_t wr_data,
    input  addr_t rd_addr [NUM_RD],
    output word_t rd_data [NUM_RD]
);

    word_t mem [2**ADDR_W]; // No reset, contents come from the host

    // Host write port
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // Every read port runs each cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_RD; i++) begin
            rd_data[i] <= mem[rd_addr[i]];
        end
    end

endmodule

/* operand_store/operand_store.sv */
/* A store with two read ports (even and odd row), B store with one.
   Host writes are dropped while the engine is busy */
module operand_store
    import mm_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        a_wr_en,
    input  logic        b_wr_en,
    input  addr_t       a_wr_addr,
    input  addr_t       b_wr_addr,
    input  word_t       a_wr_data,
    input  word_t       b_wr_data,
    mm_beat_if.store    beat,
    mm_operand_if.store opnd
);

    addr_t a_rd_addr [2];
    word_t a_rd_data [2];
    addr_t b_rd_addr [1];
    word_t b_rd_data [1];

    assign a_rd_addr[0] = beat.a_even_addr; // Port 0 serves even rows
    assign a_rd_addr[1] = beat.a_odd_addr;  // Port 1 serves odd rows
    assign b_rd_addr[0] = beat.b_addr;

    operand_ram #(
        .NUM_RD (2)
    ) u_a_ram (
        .clk     (clk),
        .wr_en   (a_wr_en && !beat.busy), // Write phase only
        .wr_addr (a_wr_addr),
        .wr_data (a_wr_data),
        .rd_addr (a_rd_addr),
        .rd_data (a_rd_data)
    );

    operand_ram #(
        .NUM_RD (1)
    ) u_b_ram (
        .clk     (clk),
        .wr_en   (b_wr_en && !beat.busy),
        .wr_addr (b_wr_addr),
        .wr_data (b_wr_data),
        .rd_addr (b_rd_addr),
        .rd_data (b_rd_data)
    );

    // Beat flags delayed to match the one-cycle read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            opnd.valid <= 1'b0;
            opnd.first <= 1'b0;
            opnd.last  <= 1'b0;
        end else begin
            opnd.valid <= beat.valid;
            opnd.first <= beat.first;
            opnd.last  <= beat.last;
        end
    end

    assign opnd.a_even = a_rd_data[0];
    assign opnd.a_odd  = a_rd_data[1];
    assign opnd.b_word = b_rd_data[0];

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the matmul testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module matmul_tb -Mdir obj_dir -o matmul_sim -f matmul.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/matmul_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0

/* verif/matmul_props.sv */
/* Control checks on matmul_top. A start counts as accepted when busy is low,
   which matches the sequencer taking start only in IDLE */
module matmul_props (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic out_valid,
    input logic done
);

    logic started; // An accepted start since reset

    always_ff @(posedge clk) begin
        if (!rst_n)
            started <= 1'b0;
        else if (start && !busy)
            started <= 1'b1;
    end

    // Results only while the engine owns the stores
    valid_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> busy)
        else $error("out_valid high while busy is low");

    done_busy_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(done && busy))
        else $error("done and busy high together");

    done_clears: assert property (@(posedge clk) disable iff (!rst_n)
        (start && !busy) |=> !done)
        else $error("done still high after an accepted start");

    quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !out_valid)
        else $error("out_valid before any start");

endmodule

bind matmul_top matmul_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .busy      (busy),
    .out_valid (out_valid),
    .done      (done)
);

/* verif/matmul_tb.sv */
/* Self-checking testbench for matmul_top. Keeps its own image of both stores,
   so the stores are only loaded through load_store while the engine is idle */
module matmul_tb
    import mm_cfg_pkg::*;
();

    logic      clk;
    logic      rst_n;
    logic      a_wr_en;
    addr_t     a_wr_addr;
    word_t     a_wr_data;
    logic      b_wr_en;
    addr_t     b_wr_addr;
    word_t     b_wr_data;
    logic      start;
    logic      busy;
    logic      out_valid;
    pair_idx_t out_pair;
    col_idx_t  out_col;
    acc_t      c_even;
    acc_t      c_odd;
    logic      done;

    word_t  a_model [2**ADDR_W]; // Expected store contents
    word_t  b_model [2**ADDR_W];
    integer seed = 61815;
    int     exp_tile;            // Results seen this run
    int     exp_pair;            // Next result coordinates, column runs fastest
    int     exp_col;
    bit     extreme_run;         // All elements at -128
    int     value_errs;
    int     order_errs;
    int     ctrl_errs;

    matmul_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // C(r, c) straight from the store layout, lane k mod 4 of word k/4
    function automatic acc_t ref_c(input int r, input int c);
        word_t wa;
        word_t wb;
        elem_t ea;
        elem_t eb;
        int    lane;
        acc_t  sum;
        sum = '0;
        for (int k = 0; k < INNER_DIM; k++) begin
            wa   = a_model[r * INNER_WORDS + k / ELEMS_PER_WORD];
            wb   = b_model[c * INNER_WORDS + k / ELEMS_PER_WORD];
            lane = k % ELEMS_PER_WORD;
            ea   = wa[lane * ELEM_W +: ELEM_W];
            eb   = wb[lane * ELEM_W +: ELEM_W];
            sum  = sum + acc_t'(ea) * acc_t'(eb);
        end
        return sum;
    endfunction

    // Compare on the falling edge, outputs settled
    always @(negedge clk) begin
        acc_t exp_even;
        acc_t exp_odd;
        if (rst_n && out_valid) begin
            exp_even = ref_c(2 * exp_pair, exp_col);
            exp_odd  = ref_c(2 * exp_pair + 1, exp_col);
            assert (exp_tile < NUM_TILES) else begin
                order_errs++;
                $display("out_valid pulse beyond the last tile at %0t", $time);
            end
            assert (int'(out_pair) == exp_pair) else begin
                order_errs++;
                $display("[FAIL] %0t out_pair got %0d exp %0d", $time, out_pair,
                         exp_pair);
            end
            assert (int'(out_col) == exp_col) else begin
                order_errs++;
                $display("[FAIL] %0t out_col got %0d exp %0d", $time, out_col,
                         exp_col);
            end
            assert (c_even == exp_even) else begin
                value_errs++;
                $display("[FAIL] %0t c_even got %0d exp %0d", $time, c_even, exp_even);
            end
            assert (c_odd == exp_odd) else begin
                value_errs++;
                $display("[FAIL] %0t c_odd got %0d exp %0d", $time, c_odd, exp_odd);
            end
            if (extreme_run) begin
                // 16 x (-128)^2, well inside ACC_W
                assert (c_even == 262144 && c_odd == 262144) else begin
                    value_errs++;
                    $display("[FAIL] %0t c_even/c_odd got %0d/%0d exp 262144", $time,
                             c_even, c_odd);
                end
            end
            exp_tile++;
            if (exp_col == B_COLS - 1) begin
                exp_col = 0;
                exp_pair++;
            end else begin
                exp_col++;
            end
        end
    end

    // Fill one whole store, random or a fixed word
    task automatic load_store(input bit to_b, input bit rnd, input word_t fill);
        word_t w;
        for (int i = 0; i < 2**ADDR_W; i++) begin
            @(posedge clk);
            #1;
            w         = rnd ? word_t'($random(seed)) : fill;
            a_wr_addr = addr_t'(i);
            b_wr_addr = addr_t'(i);
            a_wr_data = w;
            b_wr_data = w;
            a_wr_en   = !to_b;
            b_wr_en   = to_b;
            if (to_b)
                b_model[i] = w;
            else
                a_model[i] = w;
        end
        @(posedge clk);
        #1;
        a_wr_en = 1'b0;
        b_wr_en = 1'b0;
    endtask

    // Host writes during a run, model untouched since they must be dropped
    task automatic write_while_busy(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            assert (busy) else begin
                ctrl_errs++;
                $display("engine went idle before the busy writes ended");
            end
            a_wr_en   = 1'b1;
            b_wr_en   = 1'b1;
            a_wr_addr = addr_t'(i);
            b_wr_addr = addr_t'(i);
            a_wr_data = word_t'($random(seed));
            b_wr_data = ~a_wr_data;
        end
        @(posedge clk);
        #1;
        a_wr_en = 1'b0;
        b_wr_en = 1'b0;
    endtask

    task automatic start_run();
        int n;
        @(posedge clk);
        #1;
        start    = 1'b1;
        exp_tile = 0;
        exp_pair = 0;
        exp_col  = 0;
        @(posedge clk);
        #1;
        start = 1'b0;
        n     = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!busy && n < 10);
        assert (busy) else begin
            ctrl_errs++;
            $display("busy never rose after start");
        end
        assert (!done) else begin // Cleared by the accepted start
            ctrl_errs++;
            $display("[FAIL] %0t done got %0b exp 0", $time, done);
        end
    endtask

    task automatic finish_run();
        int n;
        n = 0;
        while (!done && n < 200) begin
            @(negedge clk);
            n++;
        end
        assert (done) else begin
            ctrl_errs++;
            $display("timed out waiting for done");
        end
        assert (exp_tile == NUM_TILES) else begin
            ctrl_errs++;
            $display("[FAIL] %0t out_valid count got %0d exp %0d", $time, exp_tile,
                     NUM_TILES);
        end
        assert (!busy) else begin
            ctrl_errs++;
            $display("[FAIL] %0t busy got %0b exp 0", $time, busy);
        end
        repeat (5) @(negedge clk);
        assert (done) else begin // Sticky while idle
            ctrl_errs++;
            $display("[FAIL] %0t done got %0b exp 1", $time, done);
        end
    endtask

    task automatic reset_mid_run();
        start_run();
        repeat (13) @(posedge clk);
        #1;
        rst_n = 1'b0;
        @(posedge clk); // Lands on the edge that would raise the third out_valid
        @(negedge clk);
        assert (!busy && !out_valid && !done) else begin
            ctrl_errs++;
            $display("[FAIL] %0t busy/out_valid/done got %0b%0b%0b exp 000", $time,
                     busy, out_valid, done);
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    initial begin
        rst_n       = 1'b0;
        start       = 1'b0;
        a_wr_en     = 1'b0;
        b_wr_en     = 1'b0;
        a_wr_addr   = '0;
        b_wr_addr   = '0;
        a_wr_data   = '0;
        b_wr_data   = '0;
        exp_tile    = 0;
        exp_pair    = 0;
        exp_col     = 0;
        extreme_run = 1'b0;
        value_errs  = 0;
        order_errs  = 0;
        ctrl_errs   = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        load_store(1'b0, 1'b1, '0); // Random A and B
        load_store(1'b1, 1'b1, '0);
        start_run();
        finish_run();

        load_store(1'b1, 1'b1, '0); // New B, old A
        start_run();
        finish_run();

        start_run();
        write_while_busy(8);
        finish_run();
        start_run();               // Stores still hold the pre-run data
        finish_run();

        load_store(1'b0, 1'b0, 32'h8080_8080);
        load_store(1'b1, 1'b0, 32'h8080_8080);
        extreme_run = 1'b1;
        start_run();
        finish_run();
        extreme_run = 1'b0;

        load_store(1'b0, 1'b1, '0);
        reset_mid_run();
        start_run();               // Clean run after the reset
        finish_run();

        $display("errors: value %0d, order %0d, control %0d", value_errs, order_errs,
                 ctrl_errs);
        if (value_errs + order_errs + ctrl_errs == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Hard limit on run length
    initial begin
        repeat (5000) @(posedge clk);
        $display("simulation ran past its cycle limit");
        $display("TEST FAILED");
        $finish;
    end

endmodule
